/* verilog.f */
source/pwm_regmap_pkg.sv
source/pwm_timer_pkg.sv
source/reg_bus_if.sv
source/wb_reg_slave.sv
source/reg_decoder.sv
source/pwm_channel.sv
source/watchdog.sv
source/pwm_timer_top.sv
sim/pwm_timer_checker.sv
sim/pwm_timer_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= pwm_timer_tb
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* sim/pwm_timer_tb.sv */
`timescale 1ns/1ps

module pwm_timer_tb import pwm_regmap_pkg::*; ();

	// the sum of all tests is near 5000 cycles, so this leaves a wide margin
	localparam int timeout_limit = 12000;
	localparam int wdog_div = 2;
	localparam reg_addr_t hole_addrs [6] = '{4'h3, 4'h7, 4'hb, 4'hc, 4'he, 4'hd};

	logic clk;
	logic rst;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	reg_addr_t wb_adr;
	reg_data_t wb_dat_w;
	reg_data_t wb_dat_r;
	logic wb_ack;
	logic [2:0] pwm;
	logic wdog_expired;

	int cycles = 0;
	int last_edge = 0;
	int mismatch_count = 0;
	int failure_count = 0;
	logic [31:0] got_q [$];
	logic [31:0] exp_q [$];
	string what_q [$];

	pwm_timer_top #(
		.wdog_reload(8'hff)
	) dut0 (
		.clk(clk),
		.rst(rst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.pwm(pwm),
		.wdog_expired(wdog_expired)
	);

	bind pwm_timer_top pwm_timer_checker checker0 (
		.clk(clk),
		.rst(rst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_ack(wb_ack),
		.we(bus_if.we),
		.rdt(bus_if.rdt)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_limit) begin
			failure_count++;
			$display("timeout: the run did not finish within %0d cycles", timeout_limit);
			$display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// expected read data of the register map after a given write
	function automatic reg_data_t ref_read(reg_addr_t a, reg_data_t written);
		if (a == addr_hwconfig) begin
			// version 1, three channels
			return 8'h13;
		end else if (a == addr_control) begin
			return written & 8'h01;
		end else if (a[1:0] == 2'd2 && a < 4'hc) begin
			// the clear bit never reads back
			return written & 8'hfd;
		end
		return 8'h00;
	endfunction

	// counter cleared at the enabling edge steps once on every later edge
	function automatic logic [15:0] ref_count(int en_edge, int rd_edge);
		return 16'(rd_edge - en_edge - 1);
	endfunction

	function automatic int ref_duty(int pwm_value, bit invert);
		return invert ? 256 - pwm_value : pwm_value;
	endfunction

	function automatic int ref_expiry_min(int div);
		return 255 * (div + 1);
	endfunction

	function automatic int ref_expiry_max(int div);
		return (div + 1) * 256 + 4;
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s: got %0h, expected %0h", $time, what, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic queue_check(input logic [31:0] got, input logic [31:0] exp, input string what);
		got_q.push_back(got);
		exp_q.push_back(exp);
		what_q.push_back(what);
	endtask

	always @(posedge clk) begin
		while (got_q.size() > 0) begin
			check_value(got_q.pop_front(), exp_q.pop_front(), what_q.pop_front());
		end
	end

	task automatic bus_access(input logic write, input reg_addr_t a, input reg_data_t d,
			output reg_data_t rd);
		int waited;
		waited = 0;
		@(posedge clk);
		#2;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = write;
		wb_adr = a;
		wb_dat_w = d;
		do begin
			@(posedge clk);
			#2;
			waited++;
		end while (!wb_ack && waited < 8);
		if (!wb_ack) begin
			$display("no ack from the DUT for address %h at %0t", a, $time);
			failure_count++;
		end
		last_edge = cycles;
		rd = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_write(input reg_addr_t a, input reg_data_t d);
		reg_data_t ignored;
		bus_access(1'b1, a, d, ignored);
	endtask

	task automatic wb_read(input reg_addr_t a, output reg_data_t rd);
		bus_access(1'b0, a, 8'h00, rd);
	endtask

	task automatic read_count(input int ch, output logic [15:0] value, output int low_edge);
		reg_data_t lo;
		reg_data_t hi;
		wb_read(4'(4 * ch), lo);
		low_edge = last_edge;
		wb_read(4'(4 * ch + 1), hi);
		value = {hi, lo};
	endtask

	task automatic measure_duty(input int ch, input reg_data_t value, input bit invert);
		int highs;
		highs = 0;
		wb_write(4'(4 * ch), value);
		wb_write(4'(4 * ch + 2), invert ? 8'h05 : 8'h01);
		@(posedge clk);
		// any 256 consecutive counter values cover the low byte once
		repeat (256) begin
			@(posedge clk);
			#2;
			if (pwm[2'(ch)]) begin
				highs++;
			end
		end
		wb_write(4'(4 * ch + 2), 8'h02);
		queue_check(32'(highs), 32'(ref_duty(int'(value), invert)),
			$sformatf("pwm high cycles on channel %0d, invert %0d", ch, invert));
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#2;
		rst = 1'b1;
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;
	endtask

	initial begin
		reg_data_t rd;
		reg_data_t value;
		logic [15:0] first;
		logic [15:0] second;
		logic [15:0] cleared;
		int low_edge;
		int en_edge;
		int start;
		bit stayed_low;
		clk = 1'b0;
		rst = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		void'($urandom(32'h83a5365f));
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;

		for (int ch = 0; ch < 3; ch++) begin
			repeat (4) begin
				value = 8'($urandom());
				wb_write(4'(4 * ch + 2), value);
				wb_read(4'(4 * ch + 2), rd);
				queue_check(32'(rd), 32'(ref_read(4'(4 * ch + 2), value)),
					$sformatf("config readback on channel %0d", ch));
			end
			wb_write(4'(4 * ch + 2), 8'h02);
		end
		wb_write(addr_control, 8'h01);
		wb_read(addr_control, rd);
		queue_check(32'(rd), 32'(ref_read(addr_control, 8'h01)), "control enable set");
		wb_write(addr_control, 8'h00);
		wb_read(addr_control, rd);
		queue_check(32'(rd), 32'(ref_read(addr_control, 8'h00)), "control enable cleared");

		foreach (hole_addrs[i]) begin
			wb_read(hole_addrs[i], rd);
			queue_check(32'(rd), 32'(ref_read(hole_addrs[i], 8'h00)),
				$sformatf("read of address %h", hole_addrs[i]));
		end

		// enable and clear channel 1 together, then read it twice
		// both low reads land on a low byte of ff and the high byte rolls over before it is read
		wb_write(4'h6, 8'h03);
		en_edge = last_edge;
		repeat (510) @(posedge clk);
		read_count(1, first, low_edge);
		queue_check(32'(first), 32'(ref_count(en_edge, low_edge)), "channel 1 first count");
		repeat (252) @(posedge clk);
		read_count(1, second, low_edge);
		queue_check(32'(second), 32'(ref_count(en_edge, low_edge)), "channel 1 second count");
		queue_check(32'(second >= first), 32'd1, "channel 1 count non-decreasing");
		wb_write(4'h6, 8'h02);
		read_count(1, cleared, low_edge);
		queue_check(32'(cleared), 32'd0, "channel 1 count after clear");

		for (int ch = 0; ch < 3; ch++) begin
			for (int inv = 0; inv < 2; inv++) begin
				measure_duty(ch, 8'($urandom()), inv != 0);
			end
		end

		// no kicks, so the watchdog must run out
		wb_write(addr_wdog_div, 8'(wdog_div));
		wb_write(addr_control, 8'h01);
		start = last_edge;
		while (!wdog_expired && cycles - start < ref_expiry_max(wdog_div)) begin
			@(posedge clk);
			#2;
		end
		queue_check(32'(wdog_expired), 32'd1, "wdog_expired after running out");
		queue_check(32'(cycles - start >= ref_expiry_min(wdog_div)
			&& cycles - start <= ref_expiry_max(wdog_div)), 32'd1, "expiry time in range");
		wb_read(addr_control, rd);
		// bit 7 is the sticky expired flag
		queue_check(32'(rd), 32'(ref_read(addr_control, 8'h01) | 8'h80), "control after expiry");

		apply_reset();
		wb_write(addr_wdog_div, 8'(wdog_div));
		wb_write(addr_control, 8'h01);
		stayed_low = 1'b1;
		repeat (6) begin
			repeat (300) begin
				@(posedge clk);
				#2;
				if (wdog_expired) begin
					stayed_low = 1'b0;
				end
			end
			wb_read(addr_control, rd);
			queue_check(32'(rd), 32'(ref_read(addr_control, 8'h01)), "control while kicked");
		end
		queue_check(32'(stayed_low), 32'd1, "wdog_expired low while kicked");

		repeat (2) @(posedge clk);
		#2;
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* sim/pwm_timer_checker.sv */
`timescale 1ns/1ps

module pwm_timer_checker (
	input logic clk,
	input logic rst,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack,
	input logic we,
	input logic rdt
);

	// the slave acknowledges for a single cycle and then returns to idle
	ack_one_cycle: assert property (
		@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack
	) else $error("wb_ack stayed high for more than one cycle");

	// a new ack needs a request in the cycle before it
	ack_after_request: assert property (
		@(posedge clk) disable iff (rst) $rose(wb_ack) |-> $past(wb_cyc && wb_stb)
	) else $error("wb_ack rose without a request in the previous cycle");

	strobes_exclusive: assert property (
		@(posedge clk) disable iff (rst) !(we && rdt)
	) else $error("write and read strobes were high together");

endmodule

/* source/pwm_timer_top.sv */
`timescale 1ns/1ps

module pwm_timer_top import pwm_regmap_pkg::*; import pwm_timer_pkg::*; #(
	parameter wdog_count_t wdog_reload = 8'hff
) (
	input logic clk,
	input logic rst,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input reg_addr_t wb_adr,
	input reg_data_t wb_dat_w,
	output reg_data_t wb_dat_r,
	output logic wb_ack,
	output logic [2:0] pwm,
	output logic wdog_expired
);

	reg_data_t count_low [3];
	reg_data_t count_high [3];
	reg_data_t config_rd [3];
	logic [2:0] count_read;
	logic [2:0] pwm_load;
	logic [2:0] cfg_load;
	reg_data_t control_rd;
	logic ctrl_load;
	logic div_load;
	logic kick;

	reg_bus_if bus_if ();

	wb_reg_slave slave0 (
		.clk(clk),
		.rst(rst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.bus(bus_if.master)
	);

	reg_decoder decoder0 (
		.bus(bus_if.decoder),
		.count_low_0(count_low[0]),
		.count_high_0(count_high[0]),
		.config_rd_0(config_rd[0]),
		.count_low_1(count_low[1]),
		.count_high_1(count_high[1]),
		.config_rd_1(config_rd[1]),
		.count_low_2(count_low[2]),
		.count_high_2(count_high[2]),
		.config_rd_2(config_rd[2]),
		.control_rd(control_rd),
		.count_read_0(count_read[0]),
		.pwm_load_0(pwm_load[0]),
		.cfg_load_0(cfg_load[0]),
		.count_read_1(count_read[1]),
		.pwm_load_1(pwm_load[1]),
		.cfg_load_1(cfg_load[1]),
		.count_read_2(count_read[2]),
		.pwm_load_2(pwm_load[2]),
		.cfg_load_2(cfg_load[2]),
		.ctrl_load(ctrl_load),
		.div_load(div_load),
		.kick(kick)
	);

	pwm_channel chan0 (
		.clk(clk),
		.rst(rst),
		.wdata(bus_if.wdata),
		.count_read(count_read[0]),
		.pwm_load(pwm_load[0]),
		.cfg_load(cfg_load[0]),
		.count_low(count_low[0]),
		.count_high(count_high[0]),
		.config_rd(config_rd[0]),
		.pwm(pwm[0])
	);

	pwm_channel chan1 (
		.clk(clk),
		.rst(rst),
		.wdata(bus_if.wdata),
		.count_read(count_read[1]),
		.pwm_load(pwm_load[1]),
		.cfg_load(cfg_load[1]),
		.count_low(count_low[1]),
		.count_high(count_high[1]),
		.config_rd(config_rd[1]),
		.pwm(pwm[1])
	);

	pwm_channel chan2 (
		.clk(clk),
		.rst(rst),
		.wdata(bus_if.wdata),
		.count_read(count_read[2]),
		.pwm_load(pwm_load[2]),
		.cfg_load(cfg_load[2]),
		.count_low(count_low[2]),
		.count_high(count_high[2]),
		.config_rd(config_rd[2]),
		.pwm(pwm[2])
	);

	watchdog #(
		.wdog_reload(wdog_reload)
	) wdog0 (
		.clk(clk),
		.rst(rst),
		.wdata(bus_if.wdata),
		.ctrl_load(ctrl_load),
		.div_load(div_load),
		.kick(kick),
		.control_rd(control_rd),
		.wdog_expired(wdog_expired)
	);

endmodule

/* source/watchdog.sv */
`timescale 1ns/1ps

module watchdog import pwm_regmap_pkg::*; import pwm_timer_pkg::*; #(
	parameter wdog_count_t wdog_reload = 8'hff
) (
	input logic clk,
	input logic rst,
	input reg_data_t wdata,
	input logic ctrl_load,
	input logic div_load,
	input logic kick,
	output reg_data_t control_rd,
	output logic wdog_expired
);

	logic enable;
	logic expired;
	reg_data_t divider;
	reg_data_t prescale;
	wdog_count_t count;
	logic running;

	assign running = enable && !expired;

	always_ff @(posedge clk) begin
		if (rst) begin
			enable <= 1'b0;
			divider <= '0;
		end else begin
			if (ctrl_load) begin
				enable <= wdata[ctl_wdog_enable];
			end
			if (div_load) begin
				divider <= wdata;
			end
		end
	end

	// the prescaler wraps every divider plus one cycles
	always_ff @(posedge clk) begin
		if (rst) begin
			prescale <= '0;
			count <= wdog_reload;
		end else if (kick || ctrl_load) begin
			prescale <= '0;
			count <= wdog_reload;
		end else if (running) begin
			if (prescale == divider) begin
				prescale <= '0;
				if (count != '0) begin
					count <= count - 1'b1;
				end
			end else begin
				prescale <= prescale + 1'b1;
			end
		end
	end

	// once set, only reset brings this back down
	always_ff @(posedge clk) begin
		if (rst) begin
			expired <= 1'b0;
		end else if (running && count == '0) begin
			expired <= 1'b1;
		end
	end

	always_comb begin
		control_rd = '0;
		control_rd[ctl_wdog_enable] = enable;
		control_rd[ctl_wdog_expired] = expired;
	end

	assign wdog_expired = expired;

endmodule

/* source/pwm_channel.sv */
`timescale 1ns/1ps

module pwm_channel import pwm_regmap_pkg::*; import pwm_timer_pkg::*; (
	input logic clk,
	input logic rst,
	input reg_data_t wdata,
	input logic count_read,
	input logic pwm_load,
	input logic cfg_load,
	output reg_data_t count_low,
	output reg_data_t count_high,
	output reg_data_t config_rd,
	output logic pwm
);

	count_t counter;
	reg_data_t pwm_reg;
	reg_data_t cfg_reg;
	reg_data_t high_frozen;
	logic pwm_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			pwm_reg <= '0;
			cfg_reg <= '0;
		end else begin
			if (pwm_load) begin
				pwm_reg <= wdata;
			end
			if (cfg_load) begin
				cfg_reg <= wdata;
				cfg_reg[cfg_clear] <= 1'b0;
			end
		end
	end

	// a clear request wins over counting in the same cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			counter <= '0;
		end else if (cfg_load && wdata[cfg_clear]) begin
			counter <= '0;
		end else if (cfg_reg[cfg_enable]) begin
			counter <= counter + 1'b1;
		end
	end

	// latch the upper byte while the low byte is being read out
	always_ff @(posedge clk) begin
		if (count_read) begin
			high_frozen <= counter[15:8];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pwm_q <= 1'b0;
		end else begin
			pwm_q <= (counter[7:0] < pwm_reg) ^ cfg_reg[cfg_invert];
		end
	end

	assign count_low = counter[7:0];
	assign count_high = high_frozen;
	assign config_rd = cfg_reg;
	assign pwm = pwm_q;

endmodule

/* source/reg_decoder.sv */
`timescale 1ns/1ps

module reg_decoder import pwm_regmap_pkg::*; (
	reg_bus_if.decoder bus,
	input reg_data_t count_low_0,
	input reg_data_t count_high_0,
	input reg_data_t config_rd_0,
	input reg_data_t count_low_1,
	input reg_data_t count_high_1,
	input reg_data_t config_rd_1,
	input reg_data_t count_low_2,
	input reg_data_t count_high_2,
	input reg_data_t config_rd_2,
	input reg_data_t control_rd,
	output logic count_read_0,
	output logic pwm_load_0,
	output logic cfg_load_0,
	output logic count_read_1,
	output logic pwm_load_1,
	output logic cfg_load_1,
	output logic count_read_2,
	output logic pwm_load_2,
	output logic cfg_load_2,
	output logic ctrl_load,
	output logic div_load,
	output logic kick
);

	localparam reg_addr_t ch1_base = 4'h4;
	localparam reg_addr_t ch2_base = 4'h8;

	always_comb begin
		bus.rdata = '0;
		count_read_0 = 1'b0;
		pwm_load_0 = 1'b0;
		cfg_load_0 = 1'b0;
		count_read_1 = 1'b0;
		pwm_load_1 = 1'b0;
		cfg_load_1 = 1'b0;
		count_read_2 = 1'b0;
		pwm_load_2 = 1'b0;
		cfg_load_2 = 1'b0;
		ctrl_load = 1'b0;
		div_load = 1'b0;
		kick = 1'b0;
		// writes to the count low offset load the pwm compare register
		case (bus.addr)
			ofs_count_low: begin
				bus.rdata = count_low_0;
				pwm_load_0 = bus.we;
				count_read_0 = bus.rdt;
			end
			ofs_count_high: bus.rdata = count_high_0;
			ofs_config: begin
				bus.rdata = config_rd_0;
				cfg_load_0 = bus.we;
			end
			ch1_base | ofs_count_low: begin
				bus.rdata = count_low_1;
				pwm_load_1 = bus.we;
				count_read_1 = bus.rdt;
			end
			ch1_base | ofs_count_high: bus.rdata = count_high_1;
			ch1_base | ofs_config: begin
				bus.rdata = config_rd_1;
				cfg_load_1 = bus.we;
			end
			ch2_base | ofs_count_low: begin
				bus.rdata = count_low_2;
				pwm_load_2 = bus.we;
				count_read_2 = bus.rdt;
			end
			ch2_base | ofs_count_high: bus.rdata = count_high_2;
			ch2_base | ofs_config: begin
				bus.rdata = config_rd_2;
				cfg_load_2 = bus.we;
			end
			addr_hwconfig: bus.rdata = hwconfig_value;
			// the divider is write only
			addr_wdog_div: div_load = bus.we;
			addr_control: begin
				bus.rdata = control_rd;
				ctrl_load = bus.we;
				kick = bus.rdt;
			end
			default: bus.rdata = '0;
		endcase
	end

endmodule

/* source/wb_reg_slave.sv */
`timescale 1ns/1ps

module wb_reg_slave import pwm_regmap_pkg::*; import pwm_timer_pkg::*; (
	input logic clk,
	input logic rst,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input reg_addr_t wb_adr,
	input reg_data_t wb_dat_w,
	output reg_data_t wb_dat_r,
	output logic wb_ack,
	reg_bus_if.master bus
);

	slave_state_t state;
	logic req;

	// a request is only taken in idle, so each access strobes exactly once
	assign req = (state == idle) && wb_cyc && wb_stb;

	assign bus.we = req && wb_we;
	assign bus.rdt = req && !wb_we;
	assign bus.addr = wb_adr;
	assign bus.wdata = wb_dat_w;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
		end else begin
			case (state)
				idle: begin
					if (req) begin
						state <= ack;
					end
				end
				ack: begin
					state <= idle;
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// read data is captured at the same edge as the read side effects
	always_ff @(posedge clk) begin
		if (bus.rdt) begin
			wb_dat_r <= bus.rdata;
		end
	end

	assign wb_ack = (state == ack);

endmodule

/* source/reg_bus_if.sv */
`timescale 1ns/1ps

interface reg_bus_if import pwm_regmap_pkg::*; ();

	// we and rdt are one-cycle strobes, valid together with addr
	logic we;
	logic rdt;
	reg_addr_t addr;
	reg_data_t wdata;
	reg_data_t rdata;

	modport master (
		output we,
		output rdt,
		output addr,
		output wdata,
		input rdata
	);

	modport decoder (
		input we,
		input rdt,
		input addr,
		output rdata
	);

endinterface

/* source/pwm_timer_pkg.sv */
package pwm_timer_pkg;

	// channel counter
	typedef logic [15:0] count_t;

	// channel config register fields
	localparam int unsigned cfg_enable = 0;
	// self-clearing, never stored
	localparam int unsigned cfg_clear  = 1;
	localparam int unsigned cfg_invert = 2;

	// watchdog down counter
	typedef logic [7:0] wdog_count_t;

	// control register fields
	localparam int unsigned ctl_wdog_enable  = 0;
	// read only, sticky until reset
	localparam int unsigned ctl_wdog_expired = 7;

	// bus slave handshake states
	typedef enum logic {
		idle,
		ack
	} slave_state_t;

endpackage

/* source/pwm_regmap_pkg.sv */
package pwm_regmap_pkg;

	// the register window is sixteen bytes wide
	typedef logic [3:0] reg_addr_t;
	typedef logic [7:0] reg_data_t;

	// per-channel offsets, added to a base of 4n for channel n
	localparam reg_addr_t ofs_count_low  = 4'h0;
	localparam reg_addr_t ofs_count_high = 4'h1;
	localparam reg_addr_t ofs_config     = 4'h2;

	// shared registers at the top of the window
	localparam reg_addr_t addr_hwconfig  = 4'hd;
	localparam reg_addr_t addr_wdog_div  = 4'he;
	localparam reg_addr_t addr_control   = 4'hf;

	// high nibble is the version, low nibble the channel count
	localparam reg_data_t hwconfig_value = 8'h13;

endpackage
